//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module board_tb -Mdir obj_dir
	./obj_dir/Vboard_tb | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir

//--- common/board_defs.svh
// Board bus and audio widths
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// main cpu buses
`define VD_W 16
`define VA_W 23

// sound cpu buses
`define ZD_W 8
`define ZA_W 16

// work ram address widths
`define RAM68_AW 15
`define RAMZ_AW 13

// audio sample widths
`define FM_W 9
`define FM2612_W 10
`define PSG_W 16
`define MIX_W 16
`define MIX2612_W 18

// centre of the unsigned linear fm sample
`define FM_BIAS 256

`endif

//--- common/board_pkg.sv
// Board bus and audio types
`include "board_defs.svh"

package board_pkg;

	// one driver per struct, oe is per bit and active high
	typedef struct packed {
		logic [`VD_W-1:0] data;
		logic [`VD_W-1:0] oe;
	} vd_drive_t;

	typedef struct packed {
		logic [`VA_W-1:0] data;
		logic [`VA_W-1:0] oe;
	} va_drive_t;

	typedef struct packed {
		logic [`ZD_W-1:0] data;
		logic [`ZD_W-1:0] oe;
	} zd_drive_t;

	typedef struct packed {
		logic [`ZA_W-1:0] data;
		logic [`ZA_W-1:0] oe;
	} za_drive_t;

	// 68k bus strobes, en drives the whole bundle
	typedef struct packed {
		logic as_n;
		logic uds_n;
		logic lds_n;
		logic rw;
		logic en;
	} m68k_strobe_t;

	typedef struct packed {
		logic rd_n;
		logic wr_n;
		logic mreq_n;
		logic en;
	} z80_strobe_t;

	// chipset ram controls, all active low except ia14
	typedef struct packed {
		logic ia14;
		logic uwr_n;
		logic lwr_n;
		logic ras0_n;
		logic eoe_n;
		logic noe_n;
		logic zram_n;
	} ram_ctrl_t;

	typedef struct packed {
		logic [`RAM68_AW-1:0] address;
		logic [1:0]           byteena;
		logic [`VD_W-1:0]     data;
		logic                 wren;
	} ram68_req_t;

	typedef struct packed {
		logic [`RAMZ_AW-1:0] address;
		logic [`ZD_W-1:0]    data;
		logic                wren;
	} ramz_req_t;

	// mol/mor unsigned linear, *_2612 signed dac
	typedef struct packed {
		logic [`FM_W-1:0]     mol;
		logic [`FM_W-1:0]     mor;
		logic [`FM2612_W-1:0] mol_2612;
		logic [`FM2612_W-1:0] mor_2612;
		logic [`PSG_W-1:0]    psg;
	} audio_in_t;

	typedef struct packed {
		logic [`MIX_W-1:0]     a_l;
		logic [`MIX_W-1:0]     a_r;
		logic [`MIX2612_W-1:0] a_l_2612;
		logic [`MIX2612_W-1:0] a_r_2612;
	} audio_out_t;

endpackage

//--- design/audio_mixer.sv
// FM and PSG stereo mixer
`timescale 1ns/1ps
`include "board_defs.svh"

module audio_mixer (
	input  board_pkg::audio_in_t  audio_i,
	output board_pkg::audio_out_t audio_o
);

	// unsigned fm recentred, scaled by 64, plus psg
	function automatic logic [`MIX_W-1:0] lin_mix(
		input logic [`FM_W-1:0]  fm,
		input logic [`PSG_W-1:0] psg
	);
		logic [`FM_W-1:0] fm_s;
		fm_s = fm - `FM_W'(`FM_BIAS);
		return {fm_s[`FM_W-1], fm_s, 6'h0} + psg;
	endfunction

	// signed fm times 192 as x128 plus x64
	function automatic logic [`MIX2612_W-1:0] dac_mix(
		input logic [`FM2612_W-1:0] fm,
		input logic [`PSG_W-1:0]    psg
	);
		logic [`MIX2612_W-1:0] x128;
		logic [`MIX2612_W-1:0] x64;
		x128 = {fm[`FM2612_W-1], fm, 7'h0};
		x64  = {{2{fm[`FM2612_W-1]}}, fm, 6'h0};
		return x128 + x64 + {2'h0, psg};
	endfunction

	assign audio_o.a_l      = lin_mix(audio_i.mol, audio_i.psg);
	assign audio_o.a_r      = lin_mix(audio_i.mor, audio_i.psg);
	assign audio_o.a_l_2612 = dac_mix(audio_i.mol_2612, audio_i.psg);
	assign audio_o.a_r_2612 = dac_mix(audio_i.mor_2612, audio_i.psg);

endmodule

//--- design/board_top.sv
// Mainboard bus fabric
`timescale 1ns/1ps
`include "board_defs.svh"

module board_top (
	input  logic                    MCLK2,
	input  logic                    rst_n_i,
	input  board_pkg::vd_drive_t    vd_chip_i,
	input  board_pkg::vd_drive_t    vd_cpu_i,
	input  board_pkg::va_drive_t    va_chip_i,
	input  board_pkg::va_drive_t    va_cpu_i,
	input  board_pkg::zd_drive_t    zd_chip_i,
	input  board_pkg::zd_drive_t    zd_cpu_i,
	input  board_pkg::za_drive_t    za_chip_i,
	input  board_pkg::za_drive_t    za_cpu_i,
	input  board_pkg::m68k_strobe_t m68k_chip_strb_i,
	input  board_pkg::m68k_strobe_t m68k_cpu_strb_i,
	input  board_pkg::z80_strobe_t  z80_chip_strb_i,
	input  board_pkg::z80_strobe_t  z80_cpu_strb_i,
	input  board_pkg::ram_ctrl_t    ram_ctrl_i,
	input  logic [`VD_W-1:0]        ram68_q_i,
	input  logic [`ZD_W-1:0]        ramz_q_i,
	input  board_pkg::audio_in_t    audio_i,
	output logic [`VD_W-1:0]        vd_o,
	output logic [`VA_W-1:0]        va_o,
	output logic [`ZD_W-1:0]        zd_o,
	output logic [`ZA_W-1:0]        za_o,
	output board_pkg::m68k_strobe_t m68k_strb_o,
	output board_pkg::z80_strobe_t  z80_strb_o,
	output board_pkg::ram68_req_t   ram68_req_o,
	output board_pkg::ramz_req_t    ramz_req_o,
	output board_pkg::audio_out_t   audio_o
);

	localparam int M68K_SW = $bits(board_pkg::m68k_strobe_t);
	localparam int Z80_SW  = $bits(board_pkg::z80_strobe_t);

	// work ram read-back is the third source on VD and ZD
	board_pkg::vd_drive_t ram_vd_drv;
	board_pkg::zd_drive_t ram_zd_drv;

	// main cpu data and address, undriven bits hold
	bus_merge #(.WIDTH(`VD_W), .NSRC(3), .HOLD_IDLE(1'b1)) u_vd_merge (
		.MCLK2   (MCLK2),
		.rst_n_i (rst_n_i),
		.data_i  ({vd_chip_i.data, vd_cpu_i.data, ram_vd_drv.data}),
		.oe_i    ({vd_chip_i.oe, vd_cpu_i.oe, ram_vd_drv.oe}),
		.bus_o   (vd_o)
	);

	bus_merge #(.WIDTH(`VA_W), .NSRC(2), .HOLD_IDLE(1'b1)) u_va_merge (
		.MCLK2   (MCLK2),
		.rst_n_i (rst_n_i),
		.data_i  ({va_chip_i.data, va_cpu_i.data}),
		.oe_i    ({va_chip_i.oe, va_cpu_i.oe}),
		.bus_o   (va_o)
	);

	// z80 data pulls high, address holds
	bus_merge #(.WIDTH(`ZD_W), .NSRC(3), .HOLD_IDLE(1'b0)) u_zd_merge (
		.MCLK2   (MCLK2),
		.rst_n_i (rst_n_i),
		.data_i  ({zd_chip_i.data, zd_cpu_i.data, ram_zd_drv.data}),
		.oe_i    ({zd_chip_i.oe, zd_cpu_i.oe, ram_zd_drv.oe}),
		.bus_o   (zd_o)
	);

	bus_merge #(.WIDTH(`ZA_W), .NSRC(2), .HOLD_IDLE(1'b1)) u_za_merge (
		.MCLK2   (MCLK2),
		.rst_n_i (rst_n_i),
		.data_i  ({za_chip_i.data, za_cpu_i.data}),
		.oe_i    ({za_chip_i.oe, za_cpu_i.oe}),
		.bus_o   (za_o)
	);

	// strobe bundles idle high, merged en always reads high
	bus_merge #(.WIDTH(M68K_SW), .NSRC(2), .HOLD_IDLE(1'b0)) u_m68k_strb_merge (
		.MCLK2   (MCLK2),
		.rst_n_i (rst_n_i),
		.data_i  ({m68k_chip_strb_i, m68k_cpu_strb_i}),
		.oe_i    ({{M68K_SW{m68k_chip_strb_i.en}}, {M68K_SW{m68k_cpu_strb_i.en}}}),
		.bus_o   (m68k_strb_o)
	);

	bus_merge #(.WIDTH(Z80_SW), .NSRC(2), .HOLD_IDLE(1'b0)) u_z80_strb_merge (
		.MCLK2   (MCLK2),
		.rst_n_i (rst_n_i),
		.data_i  ({z80_chip_strb_i, z80_cpu_strb_i}),
		.oe_i    ({{Z80_SW{z80_chip_strb_i.en}}, {Z80_SW{z80_cpu_strb_i.en}}}),
		.bus_o   (z80_strb_o)
	);

	// ram port runs off the registered buses
	work_ram_port u_work_ram_port (
		.vd_i        (vd_o),
		.va_i        (va_o),
		.zd_i        (zd_o),
		.za_i        (za_o),
		.ctrl_i      (ram_ctrl_i),
		.zrd_n_i     (z80_strb_o.rd_n),
		.zwr_n_i     (z80_strb_o.wr_n),
		.ram68_q_i   (ram68_q_i),
		.ramz_q_i    (ramz_q_i),
		.ram68_req_o (ram68_req_o),
		.ramz_req_o  (ramz_req_o),
		.vd_drive_o  (ram_vd_drv),
		.zd_drive_o  (ram_zd_drv)
	);

	audio_mixer u_audio_mixer (
		.audio_i (audio_i),
		.audio_o (audio_o)
	);

endmodule

//--- design/bus_merge.sv
// Shared bus resolver
`timescale 1ns/1ps

module bus_merge #(
	parameter int WIDTH     = 16,
	parameter int NSRC      = 2,
	parameter bit HOLD_IDLE = 1'b1
) (
	input  logic                        MCLK2,
	input  logic                        rst_n_i,
	input  logic [NSRC-1:0][WIDTH-1:0]  data_i,
	input  logic [NSRC-1:0][WIDTH-1:0]  oe_i,
	output logic [WIDTH-1:0]            bus_o
);

	logic [WIDTH-1:0] drv;
	logic [WIDTH-1:0] any_en;
	logic [WIDTH-1:0] overlap;
	logic [WIDTH-1:0] idle_val;
	logic [WIDTH-1:0] bus_nxt;

	// wired-or of every enabled driver
	always_comb
	begin
		drv     = '0;
		any_en  = '0;
		overlap = '0;
		for (int s = 0; s < NSRC; s++)
		begin
			overlap = overlap | (any_en & oe_i[s]);
			drv     = drv | (data_i[s] & oe_i[s]);
			any_en  = any_en | oe_i[s];
		end
	end

	// undriven bits either hold or float high
	assign idle_val = HOLD_IDLE ? bus_o : {WIDTH{1'b1}};
	assign bus_nxt  = drv | (~any_en & idle_val);

	always_ff @(posedge MCLK2 or negedge rst_n_i)
	begin
		if (!rst_n_i)
			bus_o <= {WIDTH{1'b1}};
		else
			bus_o <= bus_nxt;
	end

	// no bit may have two enabled drivers at once
	a_single_driver: assert property (
		@(posedge MCLK2) disable iff (!rst_n_i)
		overlap == '0
	) else $error("bus contention on mask %h", overlap);

endmodule

//--- design/work_ram_port.sv
// Work RAM port mapping
`timescale 1ns/1ps
`include "board_defs.svh"

module work_ram_port (
	input  logic [`VD_W-1:0]      vd_i,
	input  logic [`VA_W-1:0]      va_i,
	input  logic [`ZD_W-1:0]      zd_i,
	input  logic [`ZA_W-1:0]      za_i,
	input  board_pkg::ram_ctrl_t  ctrl_i,
	input  logic                  zrd_n_i,
	input  logic                  zwr_n_i,
	input  logic [`VD_W-1:0]      ram68_q_i,
	input  logic [`ZD_W-1:0]      ramz_q_i,
	output board_pkg::ram68_req_t ram68_req_o,
	output board_pkg::ramz_req_t  ramz_req_o,
	output board_pkg::vd_drive_t  vd_drive_o,
	output board_pkg::zd_drive_t  zd_drive_o
);

	logic upper_rd;
	logic lower_rd;
	logic z_rd;

	// va13 is replaced by the chipset's ia14
	assign ram68_req_o.address = {va_i[14], ctrl_i.ia14, va_i[12:0]};
	assign ram68_req_o.byteena = {~ctrl_i.uwr_n, ~ctrl_i.lwr_n};
	assign ram68_req_o.data    = vd_i;
	assign ram68_req_o.wren    = (~ctrl_i.uwr_n | ~ctrl_i.lwr_n) & ~ctrl_i.ras0_n;

	// z80 ram sees the low 8K of ZA
	assign ramz_req_o.address = za_i[`RAMZ_AW-1:0];
	assign ramz_req_o.data    = zd_i;
	assign ramz_req_o.wren    = ~ctrl_i.zram_n & ~zwr_n_i;

	// byte lane output enables for read-back
	assign upper_rd = ~ctrl_i.eoe_n & ~ctrl_i.ras0_n;
	assign lower_rd = ~ctrl_i.noe_n & ~ctrl_i.ras0_n;
	assign z_rd     = ~zrd_n_i & ~ctrl_i.zram_n;

	assign vd_drive_o.data = ram68_q_i;
	assign vd_drive_o.oe   = {{(`VD_W/2){upper_rd}}, {(`VD_W/2){lower_rd}}};

	assign zd_drive_o.data = ramz_q_i;
	assign zd_drive_o.oe   = {`ZD_W{z_rd}};

endmodule

//--- sim.f
+incdir+common
common/board_pkg.sv
design/bus_merge.sv
design/work_ram_port.sv
design/audio_mixer.sv
design/board_top.sv
verification/board_clock_gen.sv
verification/board_tb.sv

//--- verification/board_clock_gen.sv
// Clock and reset source
`timescale 1ns/1ps

module board_clock_gen #(
	parameter int RESET_CYCLES = 16
) (
	output logic MCLK2,
	output logic rst_n_o
);

	// 10 ns period
	initial
	begin
		MCLK2 = 1'b0;
		forever #5 MCLK2 = ~MCLK2;
	end

	initial
	begin
		rst_n_o <= 1'b0;
		repeat (RESET_CYCLES) @(posedge MCLK2);
		rst_n_o <= 1'b1;
	end

endmodule

//--- verification/board_tb.sv
// Board bus fabric testbench
`timescale 1ns/1ps
`include "board_defs.svh"

module board_tb;

	localparam int RESET_CYCLES   = 16;
	localparam int PHASE_CYCLES   = 64;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * PHASE_CYCLES + 100;
	localparam int AIN_W          = $bits(board_pkg::audio_in_t);

	logic MCLK2;
	logic rst_n_i;
	integer seed = 32'hac06_ae62;
	int errors = 0;
	int cyc = 0;
	int run_cyc;

	board_pkg::vd_drive_t    vd_chip_i, vd_cpu_i;
	board_pkg::va_drive_t    va_chip_i, va_cpu_i;
	board_pkg::zd_drive_t    zd_chip_i, zd_cpu_i;
	board_pkg::za_drive_t    za_chip_i, za_cpu_i;
	board_pkg::m68k_strobe_t m68k_chip_strb_i, m68k_cpu_strb_i, m68k_strb_o;
	board_pkg::z80_strobe_t  z80_chip_strb_i, z80_cpu_strb_i, z80_strb_o;
	board_pkg::ram_ctrl_t    ram_ctrl_i;
	logic [`VD_W-1:0]        ram68_q_i, vd_o;
	logic [`ZD_W-1:0]        ramz_q_i, zd_o;
	logic [`VA_W-1:0]        va_o;
	logic [`ZA_W-1:0]        za_o;
	board_pkg::audio_in_t    audio_i;
	board_pkg::audio_out_t   audio_o;
	board_pkg::ram68_req_t   ram68_req_o;
	board_pkg::ramz_req_t    ramz_req_o;

	// reference bus state and delayed read-back lanes
	logic [`VD_W-1:0]        exp_vd, rb_vd_q, ram68_q_q, vd_rb_mask;
	logic [`VA_W-1:0]        exp_va;
	logic [`ZD_W-1:0]        exp_zd, rb_zd_q, ramz_q_q, zd_rb_mask;
	logic [`ZA_W-1:0]        exp_za;
	board_pkg::m68k_strobe_t exp_m68k;
	board_pkg::z80_strobe_t  exp_z80;

	board_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
		.MCLK2   (MCLK2),
		.rst_n_o (rst_n_i)
	);

	board_top uut (.*);

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// per bit, the enabled source wins, otherwise hold or read one
	function automatic logic [31:0] resolve(input logic [31:0] prev, input logic hold,
		input logic [31:0] d0, input logic [31:0] e0, input logic [31:0] d1,
		input logic [31:0] e1, input logic [31:0] d2, input logic [31:0] e2);
		logic [31:0] r;
		for (int b = 0; b < 32; b++)
		begin
			if (e0[b])
				r[b] = d0[b];
			else if (e1[b])
				r[b] = d1[b];
			else if (e2[b])
				r[b] = d2[b];
			else
				r[b] = hold ? prev[b] : 1'b1;
		end
		return r;
	endfunction

	// byte lanes the 68k RAM drives back onto VD
	function automatic logic [`VD_W-1:0] vd_readback_mask(input board_pkg::ram_ctrl_t c);
		logic upper;
		logic lower;
		upper = !c.eoe_n && !c.ras0_n;
		lower = !c.noe_n && !c.ras0_n;
		return {{(`VD_W/2){upper}}, {(`VD_W/2){lower}}};
	endfunction

	function automatic board_pkg::ram68_req_t ram68_expect(input logic [`VA_W-1:0] va,
		input logic [`VD_W-1:0] vd, input board_pkg::ram_ctrl_t c);
		board_pkg::ram68_req_t r;
		r.address = {va[14], c.ia14, va[12:0]};
		r.byteena = {!c.uwr_n, !c.lwr_n};
		r.data    = vd;
		r.wren    = (!c.uwr_n || !c.lwr_n) && !c.ras0_n;
		return r;
	endfunction

	// signed view of the recentred sample, times 64, plus psg
	function automatic logic [`MIX_W-1:0] lin_expect(input logic [`FM_W-1:0] fm,
		input logic [`PSG_W-1:0] psg);
		int v;
		v = (int'(fm) - `FM_BIAS) * 64 + int'(psg);
		return `MIX_W'(v);
	endfunction

	function automatic logic [`MIX2612_W-1:0] dac_expect(input logic [`FM2612_W-1:0] fm,
		input logic [`PSG_W-1:0] psg);
		int v;
		v = int'($signed(fm)) * 192 + int'(psg);
		return `MIX2612_W'(v);
	endfunction

	task automatic log_error(input string msg);
		errors++;
		$display("** Error at %0t: %s", $time, msg);
	endtask

	task automatic print_counts();
		$display("cycles checked: %0d, errors: %0d", run_cyc, errors);
	endtask

	// one cycle of random stimulus, phase picks the behavior exercised
	task automatic drive_cycle(input int phase);
		logic [31:0] sel;
		board_pkg::ram_ctrl_t ctrl;
		sel  = rand32();
		ctrl = board_pkg::ram_ctrl_t'(7'(rand32()));
		audio_i   <= AIN_W'({rand32(), rand32()});
		ram68_q_i <= `VD_W'(rand32());
		ramz_q_i  <= `ZD_W'(rand32());
		// controls inactive and ia14 low outside the RAM phase
		ram_ctrl_i <= (phase == 2) ? ctrl : board_pkg::ram_ctrl_t'(7'h3f);
		{vd_chip_i, vd_cpu_i, va_chip_i, va_cpu_i, zd_chip_i, zd_cpu_i} <= '0;
		{za_chip_i, za_cpu_i, m68k_chip_strb_i, m68k_cpu_strb_i} <= '0;
		{z80_chip_strb_i, z80_cpu_strb_i} <= '0;
		case (phase)
			0:
			begin
				// one source per bus with a random enable mask
				if (sel[0])
					vd_chip_i <= {`VD_W'(rand32()), `VD_W'(rand32())};
				else
					vd_cpu_i <= {`VD_W'(rand32()), `VD_W'(rand32())};
				if (sel[1])
					va_chip_i <= {`VA_W'(rand32()), `VA_W'(rand32())};
				else
					va_cpu_i <= {`VA_W'(rand32()), `VA_W'(rand32())};
				if (sel[2])
					za_chip_i <= {`ZA_W'(rand32()), `ZA_W'(rand32())};
				else
					za_cpu_i <= {`ZA_W'(rand32()), `ZA_W'(rand32())};
			end
			1:
			begin
				// zd released half the time
				if (sel[1:0] == 2'd0)
					zd_chip_i <= {`ZD_W'(rand32()), `ZD_W'(rand32())};
				else if (sel[1:0] == 2'd1)
					zd_cpu_i <= {`ZD_W'(rand32()), `ZD_W'(rand32())};
				m68k_chip_strb_i <= {4'(rand32()), sel[3:2] == 2'd0};
				m68k_cpu_strb_i  <= {4'(rand32()), sel[3:2] == 2'd1};
				z80_chip_strb_i  <= {3'(rand32()), sel[5:4] == 2'd0};
				z80_cpu_strb_i   <= {3'(rand32()), sel[5:4] == 2'd1};
			end
			2:
			begin
				// chip fills the VD lanes the RAM leaves free
				vd_chip_i      <= {`VD_W'(rand32()), ~vd_readback_mask(ctrl)};
				va_cpu_i       <= {`VA_W'(rand32()), {`VA_W{1'b1}}};
				za_chip_i      <= {`ZA_W'(rand32()), {`ZA_W{1'b1}}};
				z80_cpu_strb_i <= {3'(rand32()), 1'b1};
			end
			default: ;
		endcase
	endtask

	assign vd_rb_mask = vd_readback_mask(ram_ctrl_i);
	assign zd_rb_mask = {`ZD_W{!exp_z80.rd_n && !ram_ctrl_i.zram_n}};

	always @(posedge MCLK2 or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			{exp_vd, exp_va, exp_zd, exp_za, exp_m68k, exp_z80} <= '1;
			{rb_vd_q, rb_zd_q} <= '0;
			run_cyc <= 0;
		end
		else
		begin
			exp_vd <= `VD_W'(resolve(32'(exp_vd), 1'b1, 32'(vd_chip_i.data),
				32'(vd_chip_i.oe), 32'(vd_cpu_i.data), 32'(vd_cpu_i.oe),
				32'(ram68_q_i), 32'(vd_rb_mask)));
			exp_va <= `VA_W'(resolve(32'(exp_va), 1'b1, 32'(va_chip_i.data),
				32'(va_chip_i.oe), 32'(va_cpu_i.data), 32'(va_cpu_i.oe), '0, '0));
			exp_zd <= `ZD_W'(resolve(32'(exp_zd), 1'b0, 32'(zd_chip_i.data),
				32'(zd_chip_i.oe), 32'(zd_cpu_i.data), 32'(zd_cpu_i.oe),
				32'(ramz_q_i), 32'(zd_rb_mask)));
			exp_za <= `ZA_W'(resolve(32'(exp_za), 1'b1, 32'(za_chip_i.data),
				32'(za_chip_i.oe), 32'(za_cpu_i.data), 32'(za_cpu_i.oe), '0, '0));
			exp_m68k <= m68k_chip_strb_i.en ? m68k_chip_strb_i
				: (m68k_cpu_strb_i.en ? m68k_cpu_strb_i : '1);
			exp_z80 <= z80_chip_strb_i.en ? z80_chip_strb_i
				: (z80_cpu_strb_i.en ? z80_cpu_strb_i : '1);
			rb_vd_q   <= vd_rb_mask;
			rb_zd_q   <= zd_rb_mask;
			ram68_q_q <= ram68_q_i;
			ramz_q_q  <= ramz_q_i;
			run_cyc   <= run_cyc + 1;
		end
	end

	a_reset_state: assert property (@(posedge MCLK2) disable iff (!rst_n_i)
		run_cyc == 0 |-> ({vd_o, va_o, zd_o, za_o, m68k_strb_o, z80_strb_o} == '1
		&& !ram68_req_o.wren && !ramz_req_o.wren))
		else log_error("buses or RAM write enables not idle after reset");

	a_buses: assert property (@(posedge MCLK2) disable iff (!rst_n_i)
		{vd_o, va_o, zd_o, za_o} == {exp_vd, exp_va, exp_zd, exp_za})
		else log_error($sformatf("VD VA ZD ZA %h, expected %h",
			{vd_o, va_o, zd_o, za_o}, {exp_vd, exp_va, exp_zd, exp_za}));

	a_strobes: assert property (@(posedge MCLK2) disable iff (!rst_n_i)
		{m68k_strb_o, z80_strb_o} == {exp_m68k, exp_z80})
		else log_error($sformatf("strobes %h, expected %h",
			{m68k_strb_o, z80_strb_o}, {exp_m68k, exp_z80}));

	a_ram_req: assert property (@(posedge MCLK2) disable iff (!rst_n_i)
		ram68_req_o == ram68_expect(exp_va, exp_vd, ram_ctrl_i)
		&& ramz_req_o == {exp_za[`RAMZ_AW-1:0], exp_zd, !ram_ctrl_i.zram_n && !exp_z80.wr_n})
		else log_error($sformatf("RAM requests %h %h", ram68_req_o, ramz_req_o));

	// read data lands on the bus one cycle after it is selected
	a_readback: assert property (@(posedge MCLK2) disable iff (!rst_n_i)
		((vd_o ^ ram68_q_q) & rb_vd_q) == '0 && ((zd_o ^ ramz_q_q) & rb_zd_q) == '0)
		else log_error($sformatf("read-back VD %h ZD %h, expected %h %h",
			vd_o, zd_o, ram68_q_q, ramz_q_q));

	a_audio: assert property (@(posedge MCLK2) disable iff (!rst_n_i)
		audio_o == {lin_expect(audio_i.mol, audio_i.psg), lin_expect(audio_i.mor, audio_i.psg),
		dac_expect(audio_i.mol_2612, audio_i.psg), dac_expect(audio_i.mor_2612, audio_i.psg)})
		else log_error($sformatf("audio %h for input %h", audio_o, audio_i));

	always @(posedge MCLK2)
	begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES)
		begin
			$display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
			print_counts();
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		drive_cycle(3);
		wait (rst_n_i);
		for (int p = 0; p < 4; p++)
		begin
			for (int i = 0; i < PHASE_CYCLES; i++)
			begin
				@(posedge MCLK2);
				drive_cycle(p);
			end
		end
		@(posedge MCLK2);
		drive_cycle(3);
		repeat (2) @(posedge MCLK2);
		print_counts();
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
